/* files.f */
+incdir+.
ahb_pkg.sv
cache_pkg.sv
ahb_src_port.sv
cache_ctrl.sv
cache_mem.sv
ahb_dst_port.sv
ahb_wb_cache.sv
tb_downstream_mem.sv
tb_ahb_wb_cache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the write-back cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f files.f --top-module tb_ahb_wb_cache -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1

/* tb_ahb_wb_cache.sv */
// Testbench for the AHB-Lite write-back cache
// Clock, reset, upstream driver, shadow model, checks and watchdog

`timescale 1ns/1ps
`include "wb_cache_cfg.svh"

module tb_ahb_wb_cache;

	localparam int          n_random = 60;
	localparam int          n_xact   = 10 + n_random;     // Directed plus random transfers
	localparam int          limit    = 20 + n_xact * 200; // Watchdog limit in cycles
	localparam logic [31:0] fill_pat = 32'h5a5a_0000;

	// One downstream transfer
	typedef struct packed {
		logic                  write;
		logic [`WB_W_ADDR-1:0] addr;
		logic [`WB_W_DATA-1:0] data;  // Zero for reads
	} dst_xfer_t;

	logic                        clk;
	logic                        rst_n;
	logic                        src_hready_resp;
	logic                        src_hwrite;
	ahb_pkg::htrans_e            src_htrans;
	ahb_pkg::hsize_e             src_hsize;
	logic [`WB_W_ADDR-1:0]       src_haddr;
	logic [`WB_W_DATA-1:0]       src_hwdata;
	logic [`WB_W_DATA-1:0]       src_hrdata;
	logic                        dst_hready;
	logic [`WB_W_ADDR-1:0]       dst_haddr;
	ahb_pkg::htrans_e            dst_htrans;
	logic                        dst_hwrite;
	ahb_pkg::hsize_e             dst_hsize;
	logic [`WB_W_DATA-1:0]       dst_hwdata;
	logic [`WB_W_DATA-1:0]       dst_hrdata;

	logic                        started;   // First upstream transfer issued
	logic                        chk_read;  // Read data phase in progress
	logic [`WB_W_DATA-1:0]       chk_data;
	logic [7:0]                  shadow [bit [`WB_W_ADDR-1:0]];
	logic [cache_pkg::tag_w-1:0] line_tag [`WB_DEPTH];
	logic [`WB_DEPTH-1:0]        line_valid;
	logic [`WB_DEPTH-1:0]        line_dirty;
	dst_xfer_t                   dph_xfer;  // Transfer with its data phase open
	logic                        dph_open;
	dst_xfer_t                   exp_q [$];
	dst_xfer_t                   seen_q [$];

	ahb_wb_cache dut_i (
		.clk, .rst_n, .src_hready_resp, .src_hready(src_hready_resp), .src_haddr,
		.src_hwrite, .src_htrans, .src_hsize, .src_hwdata, .src_hrdata, .dst_hready,
		.dst_haddr, .dst_htrans, .dst_hwrite, .dst_hsize, .dst_hwdata, .dst_hrdata
	);

	tb_downstream_mem mem_model_i (
		.clk, .rst_n, .haddr(dst_haddr), .htrans(dst_htrans), .hwrite(dst_hwrite),
		.hwdata(dst_hwdata), .hready(dst_hready), .hrdata(dst_hrdata)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_on_error();
		$display("TEST FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	// ------------------------------------------------------------------------
	// Shadow memory and reference line state

	function automatic logic [7:0] shadow_byte(input logic [`WB_W_ADDR-1:0] a);
		logic [31:0] word;
		if (shadow.exists(a))
			return shadow[a];
		word = {a[`WB_W_ADDR-1:2], 2'b00} ^ fill_pat; // Memory content before any write
		return word[8*a[1:0] +: 8];
	endfunction

	function automatic logic [`WB_W_DATA-1:0] shadow_word(input logic [`WB_W_ADDR-1:0] a);
		logic [`WB_W_ADDR-1:0] base;
		base = {a[`WB_W_ADDR-1:2], 2'b00};
		return {shadow_byte(base + 3), shadow_byte(base + 2), shadow_byte(base + 1),
			shadow_byte(base)};
	endfunction

	// Lanes touched by an AHB transfer of this size and offset
	function automatic logic [3:0] lane_mask(input ahb_pkg::hsize_e sz, input logic [1:0] off);
		logic [3:0] m;
		case (sz)
			ahb_pkg::BYTE: m = 4'b0001 << off;
			ahb_pkg::HALF: m = off[1] ? 4'b1100 : 4'b0011;
			default:       m = 4'b1111;
		endcase
		return m;
	endfunction

	// Expected downstream traffic, then line state and shadow update
	task automatic predict_traffic(input logic wr, input logic [`WB_W_ADDR-1:0] addr,
			input logic [3:0] mask, input logic [`WB_W_DATA-1:0] wdata);
		logic [cache_pkg::index_w-1:0] idx;
		logic [cache_pkg::tag_w-1:0]   tg;
		logic [`WB_W_ADDR-1:0]         victim;
		dst_xfer_t                     x;
		idx = addr[cache_pkg::off_w +: cache_pkg::index_w];
		tg  = addr[`WB_W_ADDR-1 -: cache_pkg::tag_w];
		exp_q.delete();
		if (!line_valid[idx] || line_tag[idx] != tg) begin
			if (line_valid[idx] && line_dirty[idx]) begin
				victim = {line_tag[idx], idx, 2'b00};
				x      = '{write: 1'b1, addr: victim, data: shadow_word(victim)};
				exp_q.push_back(x);             // Write-back first
			end
			x = '{write: 1'b0, addr: {addr[`WB_W_ADDR-1:2], 2'b00}, data: '0};
			exp_q.push_back(x);                 // Then the refill
			line_valid[idx] = 1'b1;
			line_tag[idx]   = tg;
			line_dirty[idx] = 1'b0;
		end
		if (wr) begin
			line_dirty[idx] = 1'b1;
			for (int b = 0; b < 4; b++) begin
				if (mask[b])
					shadow[{addr[`WB_W_ADDR-1:2], 2'(b)}] = wdata[8*b +: 8];
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// Checks

	idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
		!started |-> (src_hready_resp && dst_htrans == ahb_pkg::IDLE))
		else begin
			$display("FAILED src_hready_resp/dst_htrans: got %h/%h expected 1/%h",
				$sampled(src_hready_resp), $sampled(dst_htrans), ahb_pkg::IDLE);
			stop_on_error();
		end

	read_data: assert property (@(posedge clk) disable iff (!rst_n)
		(chk_read && src_hready_resp) |-> (src_hrdata == chk_data))
		else begin
			$display("FAILED src_hrdata: got %h expected %h",
				$sampled(src_hrdata), $sampled(chk_data));
			stop_on_error();
		end

	// Log every downstream transfer as its data phase completes
	always @(posedge clk) begin
		if (!rst_n) begin
			dph_open = 1'b0;
		end else begin
			if (dph_open && dst_hready) begin
				if (dph_xfer.write)
					dph_xfer.data = dst_hwdata;  // Write data is valid in the data phase
				seen_q.push_back(dph_xfer);
				dph_open = 1'b0;
			end
			if (dst_hready && dst_htrans == ahb_pkg::NONSEQ) begin
				assert (dst_hsize == ahb_pkg::WORD) else begin
					$display("FAILED dst_hsize: got %h expected %h", dst_hsize, ahb_pkg::WORD);
					stop_on_error();
				end
				dph_xfer.write = dst_hwrite;
				dph_xfer.addr  = dst_haddr;
				dph_xfer.data  = '0;
				dph_open       = 1'b1;
			end
		end
	end

	task automatic check_traffic();
		assert (seen_q.size() == exp_q.size()) else begin
			$display("Wrong number of downstream transfers: %0d seen, %0d expected",
				seen_q.size(), exp_q.size());
			stop_on_error();
		end
		foreach (exp_q[i]) begin
			assert (seen_q[i] == exp_q[i]) else begin
				$display("FAILED dst_hwrite/dst_haddr/dst_hwdata: got %h/%h/%h expected %h/%h/%h",
					seen_q[i].write, seen_q[i].addr, seen_q[i].data,
					exp_q[i].write, exp_q[i].addr, exp_q[i].data);
				stop_on_error();
			end
		end
		seen_q.delete();
	endtask

	// ------------------------------------------------------------------------
	// Upstream driver, one transfer at a time

	task automatic wait_ready();
		while (!src_hready_resp)
			@(negedge clk);
	endtask

	task automatic access(input logic wr, input logic [`WB_W_ADDR-1:0] addr,
			input ahb_pkg::hsize_e sz, input logic [`WB_W_DATA-1:0] wdata);
		logic [`WB_W_DATA-1:0] exp_word;
		exp_word = shadow_word(addr);
		predict_traffic(wr, addr, lane_mask(sz, addr[1:0]), wdata);
		src_htrans = ahb_pkg::NONSEQ;  // Address phase
		src_haddr  = addr;
		src_hwrite = wr;
		src_hsize  = sz;
		wait_ready();
		@(negedge clk);
		src_htrans = ahb_pkg::IDLE;    // Data phase
		src_hwdata = wdata;
		chk_read   = !wr;
		chk_data   = exp_word;
		wait_ready();
		@(negedge clk);
		chk_read = 1'b0;
		check_traffic();
	endtask

	initial begin
		logic [31:0]     rnd;
		logic [31:0]     addr;
		ahb_pkg::hsize_e sz;
		void'($urandom(32'he72b_c181));
		rst_n      = 1'b0;
		src_htrans = ahb_pkg::IDLE;
		src_hsize  = ahb_pkg::WORD;
		src_haddr  = '0;
		src_hwrite = 1'b0;
		src_hwdata = '0;
		started    = 1'b0;
		chk_read   = 1'b0;
		chk_data   = '0;
		line_valid = '0;
		line_dirty = '0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		repeat (4) @(negedge clk);     // Quiet bus after reset
		started = 1'b1;

		// Cold miss, then hit
		access(1'b0, 32'h0000_1040, ahb_pkg::WORD, '0);
		access(1'b0, 32'h0000_1040, ahb_pkg::WORD, '0);

		// Merges within one word
		access(1'b1, 32'h0000_1044, ahb_pkg::WORD, 32'h1234_5678);
		access(1'b0, 32'h0000_1044, ahb_pkg::WORD, '0);
		access(1'b1, 32'h0000_1045, ahb_pkg::BYTE, 32'ha5a5_a5a5);
		access(1'b0, 32'h0000_1044, ahb_pkg::WORD, '0);
		access(1'b1, 32'h0000_1046, ahb_pkg::HALF, 32'hbeef_c0de);
		access(1'b0, 32'h0000_1044, ahb_pkg::WORD, '0);

		// Other tag on the same index sends the dirty word out before the refill
		access(1'b0, 32'h0000_1084, ahb_pkg::WORD, '0);
		access(1'b0, 32'h0000_1044, ahb_pkg::WORD, '0);

		// Random mix over 4 lines and 3 tags
		for (int n = 0; n < n_random; n++) begin
			rnd  = $urandom;
			addr = 32'h0000_2000 + ((rnd % 3) << 6) + {28'd0, rnd[3:2], 2'b00};
			case (rnd[5:4])
				2'd0: begin
					sz        = ahb_pkg::BYTE;
					addr[1:0] = rnd[7:6];
				end
				2'd1: begin
					sz        = ahb_pkg::HALF;
					addr[1:0] = {rnd[7], 1'b0};
				end
				default: sz = ahb_pkg::WORD;
			endcase
			access(rnd[8], addr, sz, $urandom);
		end

		$display("TEST PASS");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (limit) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		stop_on_error();
	end

endmodule

/* tb_downstream_mem.sv */
// AHB-Lite memory model for the cache testbench
// Random wait states, address-derived initial content

`timescale 1ns/1ps
`include "wb_cache_cfg.svh"

module tb_downstream_mem (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`WB_W_ADDR-1:0] haddr,
	input  ahb_pkg::htrans_e      htrans,
	input  logic                  hwrite,
	input  logic [`WB_W_DATA-1:0] hwdata,
	output logic                  hready,
	output logic [`WB_W_DATA-1:0] hrdata
);

	logic [`WB_W_DATA-1:0] mem [bit [`WB_W_ADDR-1:0]]; // Written words only
	logic                  dph_active;                 // Data phase in the coming cycle
	logic                  dph_write;
	logic [`WB_W_ADDR-1:0] dph_addr;
	int unsigned           wait_cnt;

	// Untouched words hold their own address XOR a fixed pattern
	function automatic logic [`WB_W_DATA-1:0] read_word(input logic [`WB_W_ADDR-1:0] a);
		if (mem.exists(a))
			return mem[a];
		return a ^ 32'h5a5a_0000;
	endfunction

	// Each negedge settles hready and hrdata up to the next posedge
	initial begin
		hready     = 1'b1;
		hrdata     = '0;
		dph_active = 1'b0;
		dph_write  = 1'b0;
		dph_addr   = '0;
		wait_cnt   = 0;
		forever begin
			@(negedge clk);
			if (!rst_n) begin
				hready     = 1'b1;
				dph_active = 1'b0;
			end else if (dph_active && wait_cnt != 0) begin
				hready   = 1'b0;           // Wait state
				wait_cnt = wait_cnt - 1;
			end else begin
				hready = 1'b1;
				if (dph_active && dph_write)
					mem[dph_addr] = hwdata; // Write completes at the coming posedge
				else if (dph_active)
					hrdata = read_word(dph_addr);
				// Address phase, if any, is taken at the coming posedge
				dph_active = (htrans == ahb_pkg::NONSEQ);
				if (dph_active) begin
					dph_write = hwrite;
					dph_addr  = {haddr[`WB_W_ADDR-1:2], 2'b00};
					wait_cnt  = $urandom % 4; // 0 to 3 wait states
				end
			end
		end
	end

endmodule

/* ahb_wb_cache.sv */
// Write-back cache top level
// Upstream port, controller, arrays and downstream port

`timescale 1ns/1ps
`include "wb_cache_cfg.svh"

module ahb_wb_cache (
	input  logic                     clk,
	input  logic                     rst_n,
	// Upstream AHB-Lite slave
	output logic                     src_hready_resp,
	input  logic                     src_hready,
	input  logic [`WB_W_ADDR-1:0]    src_haddr,
	input  logic                     src_hwrite,
	input  ahb_pkg::htrans_e         src_htrans,
	input  ahb_pkg::hsize_e          src_hsize,
	input  logic [`WB_W_DATA-1:0]    src_hwdata,
	output logic [`WB_W_DATA-1:0]    src_hrdata,
	// Downstream AHB-Lite master
	input  logic                     dst_hready,
	output logic [`WB_W_ADDR-1:0]    dst_haddr,
	output ahb_pkg::htrans_e         dst_htrans,
	output logic                     dst_hwrite,
	output ahb_pkg::hsize_e          dst_hsize,
	output logic [`WB_W_DATA-1:0]    dst_hwdata,
	input  logic [`WB_W_DATA-1:0]    dst_hrdata
);

	ahb_pkg::src_req_t       src_req;
	cache_pkg::mem_cmd_t     mem_cmd;
	cache_pkg::mem_status_t  mem_status;
	cache_pkg::dst_cmd_t     dst_cmd;
	logic [`WB_W_ADDR-1:0]   lookup_addr;
	logic [`WB_W_DATA-1:0]   hwdata;
	logic [`WB_W_DATA-1:0]   mem_rdata;
	logic [`WB_W_DATA-1:0]   fill_data;
	logic                    sel_fill_data;
	logic                    dst_done;

	ahb_src_port src_port_i (
		.clk, .rst_n, .src_hready, .src_hwrite, .src_htrans, .src_hsize,
		.src_haddr, .src_hwdata, .sel_fill_data, .mem_rdata, .fill_data,
		.src_req, .src_hwdata_out(hwdata), .src_hrdata, .lookup_addr
	);

	cache_ctrl ctrl_i (
		.clk, .rst_n, .src_req, .lookup_addr, .mem_status, .dst_done,
		.src_hready_resp, .sel_fill_data, .mem_cmd, .dst_cmd
	);

	cache_mem mem_i (
		.clk, .rst_n, .mem_cmd, .src_wdata(hwdata), .fill_wdata(fill_data),
		.rdata(mem_rdata), .mem_status
	);

	ahb_dst_port dst_port_i (
		.clk, .rst_n, .dst_cmd, .victim_data(mem_rdata), .dst_hready, .dst_hrdata,
		.dst_haddr, .dst_htrans, .dst_hwrite, .dst_hsize, .dst_hwdata, .dst_done,
		.fill_data
	);

endmodule

/* ahb_dst_port.sv */
// Downstream AHB-Lite master port
// Single NONSEQ phases, write data latch, fill word register

`timescale 1ns/1ps
`include "wb_cache_cfg.svh"

module ahb_dst_port (
	input  logic                     clk,
	input  logic                     rst_n,
	input  cache_pkg::dst_cmd_t      dst_cmd,
	input  logic [`WB_W_DATA-1:0]    victim_data,
	input  logic                     dst_hready,
	input  logic [`WB_W_DATA-1:0]    dst_hrdata,
	output logic [`WB_W_ADDR-1:0]    dst_haddr,
	output ahb_pkg::htrans_e         dst_htrans,
	output logic                     dst_hwrite,
	output ahb_pkg::hsize_e          dst_hsize,
	output logic [`WB_W_DATA-1:0]    dst_hwdata,
	output logic                     dst_done,
	output logic [`WB_W_DATA-1:0]    fill_data
);

	logic                  aph_taken;
	logic                  dph_pend;   // Data phase outstanding
	logic                  dph_write;
	logic [`WB_W_DATA-1:0] fill_q;

	assign aph_taken = dst_hready && (dst_htrans == ahb_pkg::NONSEQ);
	assign dst_done  = dph_pend && dst_hready;

	// Address phase, held while hready is low
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dst_htrans <= ahb_pkg::IDLE;
			dst_haddr  <= '0;
			dst_hwrite <= 1'b0;
			dph_pend   <= 1'b0;
			dph_write  <= 1'b0;
		end else begin
			if (dst_cmd.start) begin
				dst_htrans <= ahb_pkg::NONSEQ;
				dst_haddr  <= dst_cmd.addr;
				dst_hwrite <= dst_cmd.write;
			end else if (aph_taken) begin
				dst_htrans <= ahb_pkg::IDLE;
			end
			if (aph_taken) begin
				dph_pend  <= 1'b1;
				dph_write <= dst_hwrite;
			end else if (dst_done) begin
				dph_pend <= 1'b0;
			end
		end
	end

	assign dst_hsize = (dst_htrans == ahb_pkg::NONSEQ) ? ahb_pkg::WORD : ahb_pkg::BYTE;

	// Victim word kept for the clean data phase
	always_ff @(posedge clk) begin
		if (dst_cmd.start && dst_cmd.write)
			dst_hwdata <= victim_data;
		if (dst_done && !dph_write)
			fill_q <= dst_hrdata;
	end

	// Forward the word in its completing cycle for the line fill
	assign fill_data = (dst_done && !dph_write) ? dst_hrdata : fill_q;

endmodule

/* cache_mem.sv */
// Direct-mapped cache arrays
// Tag, valid, dirty and data storage with registered lookup

`timescale 1ns/1ps
`include "wb_cache_cfg.svh"

module cache_mem (
	input  logic                     clk,
	input  logic                     rst_n,
	input  cache_pkg::mem_cmd_t      mem_cmd,
	input  logic [`WB_W_DATA-1:0]    src_wdata,
	input  logic [`WB_W_DATA-1:0]    fill_wdata,
	output logic [`WB_W_DATA-1:0]    rdata,
	output cache_pkg::mem_status_t   mem_status
);

	localparam int n_lanes = `WB_W_DATA / 8;

	logic [`WB_W_DATA-1:0]         data_mem [`WB_DEPTH];
	logic [cache_pkg::tag_w-1:0]   tag_mem  [`WB_DEPTH];
	logic [`WB_DEPTH-1:0]          valid_bits;
	logic [`WB_DEPTH-1:0]          dirty_bits;

	logic [cache_pkg::index_w-1:0] index;
	logic [cache_pkg::tag_w-1:0]   tag;
	logic [`WB_W_DATA-1:0]         wdata;

	// Lookup result registers
	logic [cache_pkg::tag_w-1:0]   rd_tag_q;
	logic [cache_pkg::tag_w-1:0]   req_tag_q;
	logic                          rd_valid_q;
	logic                          rd_dirty_q;

	assign index = mem_cmd.addr[cache_pkg::off_w +: cache_pkg::index_w];
	assign tag   = mem_cmd.addr[`WB_W_ADDR-1 -: cache_pkg::tag_w];
	assign wdata = mem_cmd.wsel_src ? src_wdata : fill_wdata;

	// Data and tag arrays
	always_ff @(posedge clk) begin
		if (mem_cmd.ren) begin
			rdata     <= data_mem[index];
			rd_tag_q  <= tag_mem[index];
			req_tag_q <= tag;
		end
		if (mem_cmd.wen_fill) begin
			data_mem[index] <= wdata;  // Whole line
			tag_mem[index]  <= tag;
		end else begin
			for (int b = 0; b < n_lanes; b++) begin
				if (mem_cmd.wmask[b])
					data_mem[index][8*b +: 8] <= wdata[8*b +: 8];
			end
		end
	end

	// Line state bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_bits <= '0;
			dirty_bits <= '0;
			rd_valid_q <= 1'b0;
			rd_dirty_q <= 1'b0;
		end else begin
			if (mem_cmd.ren) begin
				rd_valid_q <= valid_bits[index];
				rd_dirty_q <= dirty_bits[index];
			end
			if (mem_cmd.wen_fill) begin
				valid_bits[index] <= 1'b1;
				dirty_bits[index] <= 1'b0;   // Fresh from downstream
			end else if (|mem_cmd.wmask) begin
				dirty_bits[index] <= 1'b1;
			end
		end
	end

	assign mem_status.hit        = rd_valid_q && (rd_tag_q == req_tag_q);
	assign mem_status.dirty      = rd_valid_q && rd_dirty_q;
	assign mem_status.victim_tag = rd_tag_q;

endmodule

/* cache_ctrl.sv */
// Cache controller
// Hit check, dirty victim write-back and line refill FSM

`timescale 1ns/1ps
`include "wb_cache_cfg.svh"

module cache_ctrl (
	input  logic                     clk,
	input  logic                     rst_n,
	input  ahb_pkg::src_req_t        src_req,
	input  logic [`WB_W_ADDR-1:0]    lookup_addr,
	input  cache_pkg::mem_status_t   mem_status,
	input  logic                     dst_done,
	output logic                     src_hready_resp,
	output logic                     sel_fill_data,
	output cache_pkg::mem_cmd_t      mem_cmd,
	output cache_pkg::dst_cmd_t      dst_cmd
);

	cache_pkg::ctrl_state_e state;
	cache_pkg::ctrl_state_e next_or_idle;
	logic                   in_check;
	logic                   miss;
	logic                   in_modify;
	logic [`WB_W_ADDR-1:0]  victim_addr;
	logic [`WB_W_ADDR-1:0]  fill_addr;

	// Where to go when a new aphase may be accepted
	assign next_or_idle = !src_req.valid ? cache_pkg::IDLE :
		src_req.write ? cache_pkg::WRITE_CHECK : cache_pkg::READ_CHECK;

	assign in_check = (state == cache_pkg::READ_CHECK) || (state == cache_pkg::WRITE_CHECK);
	assign miss     = in_check && !mem_status.hit;

	// ------------------------------------------------------------------------
	// State machine

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= cache_pkg::IDLE;
		end else begin
			case (state)
				cache_pkg::IDLE: state <= next_or_idle;
				cache_pkg::READ_CHECK, cache_pkg::WRITE_CHECK: begin
					if (!mem_status.hit)
						state <= mem_status.dirty ? cache_pkg::CLEAN_WAIT : cache_pkg::FILL_WAIT;
					else if (state == cache_pkg::WRITE_CHECK)
						state <= cache_pkg::WRITE_DONE; // Bytes written this cycle
					else
						state <= next_or_idle;
				end
				cache_pkg::CLEAN_WAIT: if (dst_done) begin
					state <= cache_pkg::FILL_WAIT;      // Fill launched alongside
				end
				cache_pkg::FILL_WAIT: if (dst_done) begin
					// Request write flag picks the path after refill
					state <= src_req.write ? cache_pkg::WRITE_MODIFY : cache_pkg::READ_DONE;
				end
				cache_pkg::WRITE_MODIFY: state <= cache_pkg::WRITE_DONE;
				cache_pkg::READ_DONE, cache_pkg::WRITE_DONE: state <= next_or_idle;
				default: state <= cache_pkg::IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Upstream response

	assign src_hready_resp = (state == cache_pkg::IDLE) ||
		(state == cache_pkg::READ_CHECK && mem_status.hit) ||
		(state == cache_pkg::READ_DONE) ||
		(state == cache_pkg::WRITE_DONE);
	assign sel_fill_data = state == cache_pkg::READ_DONE; // Registered fill word

	// ------------------------------------------------------------------------
	// Cache memory steering

	assign in_modify = (state == cache_pkg::WRITE_CHECK && mem_status.hit) ||
		(state == cache_pkg::WRITE_MODIFY);

	// Lookup whenever upstream may start a phase, else the request line
	assign mem_cmd.addr     = src_hready_resp ? lookup_addr : src_req.addr;
	assign mem_cmd.ren      = src_hready_resp;
	assign mem_cmd.wen_fill = (state == cache_pkg::FILL_WAIT) && dst_done;
	assign mem_cmd.wmask    = in_modify ? src_req.mask : '0;
	assign mem_cmd.wsel_src = in_modify;

	// ------------------------------------------------------------------------
	// Downstream requests

	assign victim_addr = {mem_status.victim_tag,
		src_req.addr[cache_pkg::off_w +: cache_pkg::index_w], {cache_pkg::off_w{1'b0}}};
	assign fill_addr   = {src_req.addr[`WB_W_ADDR-1:cache_pkg::off_w], {cache_pkg::off_w{1'b0}}};

	assign dst_cmd.start = miss || (state == cache_pkg::CLEAN_WAIT && dst_done);
	assign dst_cmd.write = miss && mem_status.dirty;  // Clean goes first
	assign dst_cmd.addr  = dst_cmd.write ? victim_addr : fill_addr;

endmodule

/* ahb_src_port.sv */
// Upstream AHB-Lite slave port
// Address phase capture, byte mask build, read data select

`timescale 1ns/1ps
`include "wb_cache_cfg.svh"

module ahb_src_port (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     src_hready,
	input  logic                     src_hwrite,
	input  ahb_pkg::htrans_e         src_htrans,
	input  ahb_pkg::hsize_e          src_hsize,
	input  logic [`WB_W_ADDR-1:0]    src_haddr,
	input  logic [`WB_W_DATA-1:0]    src_hwdata,
	input  logic                     sel_fill_data,
	input  logic [`WB_W_DATA-1:0]    mem_rdata,
	input  logic [`WB_W_DATA-1:0]    fill_data,
	output ahb_pkg::src_req_t        src_req,
	output logic [`WB_W_DATA-1:0]    src_hwdata_out,
	output logic [`WB_W_DATA-1:0]    src_hrdata,
	output logic [`WB_W_ADDR-1:0]    lookup_addr
);

	logic                     accept;
	logic [`WB_W_DATA/8-1:0]  mask_live;
	logic [`WB_W_ADDR-1:0]    addr_q;
	logic                     write_q;
	logic [`WB_W_DATA/8-1:0]  mask_q;

	assign accept = src_hready && (src_htrans == ahb_pkg::NONSEQ);

	// Byte lanes from size and low address bits
	always_comb begin
		case (src_hsize)
			ahb_pkg::BYTE: mask_live = 4'b0001 << src_haddr[cache_pkg::off_w-1:0];
			ahb_pkg::HALF: mask_live = 4'b0011 << {src_haddr[1], 1'b0};
			default:       mask_live = 4'b1111;
		endcase
	end

	// Hold the last accepted phase for the data phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			addr_q  <= '0;
			write_q <= 1'b0;
			mask_q  <= '0;
		end else if (accept) begin
			addr_q  <= src_haddr;
			write_q <= src_hwrite;
			mask_q  <= mask_live;
		end
	end

	// Live fields in the accepting cycle, held ones after
	assign src_req.valid = accept;
	assign src_req.addr  = accept ? src_haddr  : addr_q;
	assign src_req.write = accept ? src_hwrite : write_q;
	assign src_req.mask  = accept ? mask_live  : mask_q;

	assign lookup_addr    = src_haddr;  // Synchronous lookup during aphase
	assign src_hwdata_out = src_hwdata;
	assign src_hrdata     = sel_fill_data ? fill_data : mem_rdata;

endmodule

/* cache_pkg.sv */
// Cache types
// Controller states, memory command/status and downstream command

`include "wb_cache_cfg.svh"

package cache_pkg;

	localparam int off_w   = $clog2(`WB_W_DATA / 8);   // Byte offset bits
	localparam int index_w = $clog2(`WB_DEPTH);        // Line index bits
	localparam int tag_w   = `WB_W_ADDR - index_w - off_w;

	typedef enum logic [3:0] {
		IDLE,         // No upstream data phase in progress
		READ_CHECK,   // Status and read data valid
		WRITE_CHECK,  // Status valid, hit writes bytes now
		CLEAN_WAIT,   // Dirty victim going downstream
		FILL_WAIT,    // Fresh line coming from downstream
		READ_DONE,    // Registered fill word goes upstream
		WRITE_MODIFY, // Merge upstream bytes into filled line
		WRITE_DONE    // OKAY to upstream
	} ctrl_state_e;

	// Controller to cache memory
	typedef struct packed {
		logic [`WB_W_ADDR-1:0]    addr;
		logic                     ren;      // Lookup read
		logic                     wen_fill; // Whole-line write leaves the line valid and clean
		logic [`WB_W_DATA/8-1:0]  wmask;    // Byte writes mark the line dirty
		logic                     wsel_src; // Set selects upstream data, clear selects fill data
	} mem_cmd_t;

	// Cache memory to controller, from the last lookup
	typedef struct packed {
		logic             hit;
		logic             dirty;
		logic [tag_w-1:0] victim_tag;
	} mem_status_t;

	// Controller to downstream port
	typedef struct packed {
		logic                  start; // Launch one NONSEQ phase
		logic                  write;
		logic [`WB_W_ADDR-1:0] addr;  // Word aligned
	} dst_cmd_t;

endpackage

/* ahb_pkg.sv */
// AHB-Lite bus types
// HTRANS and HSIZE encodings, upstream request struct

`include "wb_cache_cfg.svh"

package ahb_pkg;

	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01, // Not generated or expected here
		NONSEQ = 2'b10,
		SEQ    = 2'b11  // Not generated or expected here
	} htrans_e;

	typedef enum logic [2:0] {
		BYTE = 3'd0,
		HALF = 3'd1,
		WORD = 3'd2
	} hsize_e;

	// Accepted upstream address phase
	typedef struct packed {
		logic                     valid; // High in the cycle that ends an accepted aphase
		logic [`WB_W_ADDR-1:0]    addr;
		logic                     write;
		logic [`WB_W_DATA/8-1:0]  mask;  // Byte lanes touched by the transfer
	} src_req_t;

endpackage

/* wb_cache_cfg.svh */
// Build-time sizes of the write-back cache
// Address width, data width and line count

`ifndef WB_CACHE_CFG_SVH
`define WB_CACHE_CFG_SVH

// Bus widths
`define WB_W_ADDR 32
`define WB_W_DATA 32

// Number of lines, one bus word each
`define WB_DEPTH 16

`endif
